// ==== flist.f ====
+incdir+tests
rtl/v850_dec_pkg.sv
rtl/gr_file.sv
rtl/cond_eval.sv
rtl/inst_fifo.sv
rtl/field_decode.sv
rtl/op_issue.sv
rtl/v850_decode_top.sv
tests/tb_v850_decode.sv

// ==== rtl/cond_eval.sv ====
`timescale 1ns/1ps

module cond_eval (
    input  v850_dec_pkg::cond_e cond_i,
    input  v850_dec_pkg::psw_t  psw_i,
    output logic                cond_ok_o,
    output logic                cond_valid_o
);

    import v850_dec_pkg::*;

    logic lt;   // Signed less-than
    logic le;   // Signed less-or-equal

    assign lt = psw_i.s ^ psw_i.ov;
    assign le = lt | psw_i.z;

    always_comb begin
        case (cond_i)
            COND_V:   cond_ok_o = psw_i.ov;
            COND_NV:  cond_ok_o = !psw_i.ov;
            COND_C:   cond_ok_o = psw_i.cy;              // Also L
            COND_NC:  cond_ok_o = !psw_i.cy;             // Also NL
            COND_Z:   cond_ok_o = psw_i.z;
            COND_NZ:  cond_ok_o = !psw_i.z;
            COND_NH:  cond_ok_o = psw_i.cy | psw_i.z;
            COND_H:   cond_ok_o = !(psw_i.cy | psw_i.z);
            COND_N:   cond_ok_o = psw_i.s;
            COND_P:   cond_ok_o = !psw_i.s;
            COND_T:   cond_ok_o = 1'b1;
            COND_SAT: cond_ok_o = psw_i.sat;             // Bcond only
            COND_LT:  cond_ok_o = lt;
            COND_GE:  cond_ok_o = !lt;
            COND_LE:  cond_ok_o = le;
            COND_GT:  cond_ok_o = !le;
            default:  cond_ok_o = 1'b0;
        endcase
    end

    // ADF has no SAT form
    assign cond_valid_o = (cond_i != COND_SAT);

endmodule

// ==== rtl/field_decode.sv ====
`timescale 1ns/1ps

module field_decode (
    input  v850_dec_pkg::fetch_t                head_i,
    input  logic [v850_dec_pkg::XLEN-1:0]       rdata_a_i,
    input  logic [v850_dec_pkg::XLEN-1:0]       rdata_b_i,
    input  logic                                cond_ok_i,
    input  logic                                cond_valid_i,
    output logic [v850_dec_pkg::REG_ADDR_W-1:0] ra_o,
    output logic [v850_dec_pkg::REG_ADDR_W-1:0] rb_o,
    output v850_dec_pkg::cond_e                 cond_o,
    output v850_dec_pkg::dec_op_t               dec_o,
    output logic                                issue_o
);

    import v850_dec_pkg::*;

    fmt_i_t          fi;
    fmt_iii_t        fiii;
    fmt_vi_t         fvi;
    fmt_xi_t         fxi;
    fmt_xii_t        fxii;
    logic            is_bcond;
    logic            is_adf;
    logic            is_xii;
    logic [XLEN-1:0] imm5_sx;
    logic [XLEN-1:0] imm16_sx;
    logic [XLEN-1:0] imm16_zx;
    logic [XLEN-1:0] disp9_sx;
    logic [XLEN-1:0] bsh_val;
    logic [XLEN-1:0] bsw_val;

    // Same word, viewed per format
    assign fi   = head_i.inst.fmt_i;
    assign fiii = head_i.inst.fmt_iii;
    assign fvi  = head_i.inst.fmt_vi;
    assign fxi  = head_i.inst.fmt_xi;
    assign fxii = head_i.inst.fmt_xii;

    // reg1 and reg2 sit at the same bits in every kept format
    assign ra_o = fi.reg1;
    assign rb_o = fi.reg2;

    assign is_bcond = (fiii.opcode == BCOND_OP);
    assign is_adf   = (fxi.opcode == OP_EXT)
                    && ({fxi.sub_hi, 4'b0000, fxi.sub_lo} == SUB_ADF);  // cccc masked out
    assign is_xii   = (fxii.opcode == OP_EXT) && (fxii.reg1 == '0);

    // Bcond tests bits 3:0, ADF bits 20:17
    assign cond_o = is_bcond ? fiii.cond : fxi.cond;

    assign imm5_sx  = {{(XLEN-5){fi.reg1[4]}}, fi.reg1};
    assign imm16_sx = {{(XLEN-16){fvi.imm16[15]}}, fvi.imm16};
    assign imm16_zx = {{(XLEN-16){1'b0}}, fvi.imm16};
    assign disp9_sx = {{(XLEN-9){fiii.disp_hi[4]}}, fiii.disp_hi, fiii.disp_lo, 1'b0};

    // Byte swap inside each halfword
    assign bsh_val = {rdata_b_i[23:16], rdata_b_i[31:24], rdata_b_i[7:0], rdata_b_i[15:8]};
    // Full byte reversal
    assign bsw_val = {rdata_b_i[7:0], rdata_b_i[15:8], rdata_b_i[23:16], rdata_b_i[31:24]};

    always_comb begin
        dec_o   = '0;
        issue_o = 1'b0;
        case (fi.opcode)
            OP_ADD: begin                       // ADD reg1, reg2
                dec_o.opa  = rdata_a_i;
                dec_o.opb  = rdata_b_i;
                dec_o.dest = fi.reg2;
                dec_o.unit = UNIT_ADD;
                issue_o    = 1'b1;
            end
            OP_ADD_IMM5: begin                  // ADD imm5, reg2
                dec_o.opa  = imm5_sx;
                dec_o.opb  = rdata_b_i;
                dec_o.dest = fi.reg2;
                dec_o.unit = UNIT_ADD;
                issue_o    = 1'b1;
            end
            OP_ADDI: begin
                dec_o.opa  = rdata_a_i;
                dec_o.opb  = imm16_sx;
                dec_o.dest = fvi.reg2;
                dec_o.unit = UNIT_ADD;
                issue_o    = 1'b1;
            end
            OP_AND: begin
                dec_o.opa  = rdata_a_i;
                dec_o.opb  = rdata_b_i;
                dec_o.dest = fi.reg2;
                dec_o.unit = UNIT_AND;
                issue_o    = 1'b1;
            end
            OP_ANDI: begin
                dec_o.opa  = rdata_a_i;
                dec_o.opb  = imm16_zx;          // Logical immediate, no sign
                dec_o.dest = fvi.reg2;
                dec_o.unit = UNIT_AND;
                issue_o    = 1'b1;
            end
            OP_EXT: begin
                if (is_adf) begin
                    dec_o.opa  = rdata_a_i;
                    dec_o.opb  = rdata_b_i;
                    dec_o.incr = cond_ok_i;     // Condition feeds carry-in
                    dec_o.dest = fxi.reg3;
                    dec_o.unit = UNIT_ADD;
                    issue_o    = cond_valid_i;  // cccc 1101 dropped
                end else if (is_xii && (fxii.sub == SUB_BSH)) begin
                    dec_o.opb  = bsh_val;
                    dec_o.dest = fxii.reg3;
                    dec_o.unit = UNIT_BSH;
                    issue_o    = 1'b1;
                end else if (is_xii && (fxii.sub == SUB_BSW)) begin
                    dec_o.opb  = bsw_val;
                    dec_o.dest = fxii.reg3;
                    dec_o.unit = UNIT_BSW;
                    issue_o    = 1'b1;
                end
            end
            default: begin
                // Taken branch only, target formed in execute
                if (is_bcond && cond_ok_i) begin
                    dec_o.opa  = disp9_sx;
                    dec_o.opb  = head_i.pc;
                    dec_o.dest = '0;
                    dec_o.unit = UNIT_ADD;
                    issue_o    = 1'b1;
                end
            end
        endcase
    end

endmodule

// ==== rtl/gr_file.sv ====
`timescale 1ns/1ps

module gr_file (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  v850_dec_pkg::wb_t                   wb_i,
    input  logic [v850_dec_pkg::REG_ADDR_W-1:0] ra_i,
    input  logic [v850_dec_pkg::REG_ADDR_W-1:0] rb_i,
    output logic [v850_dec_pkg::XLEN-1:0]       rdata_a_o,
    output logic [v850_dec_pkg::XLEN-1:0]       rdata_b_o
);

    import v850_dec_pkg::*;

    // r0 has no storage
    logic [XLEN-1:0] regs [1:NUM_GR-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_GR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin  // Writes to r0 dropped
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // Combinational read, new value seen the cycle after the write
    always_comb begin
        if (ra_i == '0) begin
            rdata_a_o = '0;
        end else begin
            rdata_a_o = regs[ra_i];
        end
    end

    always_comb begin
        if (rb_i == '0) begin
            rdata_b_o = '0;
        end else begin
            rdata_b_o = regs[rb_i];
        end
    end

endmodule

// ==== rtl/inst_fifo.sv ====
`timescale 1ns/1ps

module inst_fifo #(
    parameter int IN_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 push_i,
    input  v850_dec_pkg::fetch_t data_i,
    input  logic                 pop_i,
    output logic                 head_valid_o,
    output v850_dec_pkg::fetch_t head_o,
    output logic                 credit_o
);

    import v850_dec_pkg::*;

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    fetch_t           mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Payload storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_o <= pop_i;  // One credit back per entry freed
        end
    end

    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];

    // Fetch may only send while holding a credit, so a full buffer never sees a push
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        push_i |-> (count != CNT_W'(IN_DEPTH))
    ) else $error("inst_fifo: push while full, fetch credit violation");

endmodule

// ==== rtl/op_issue.sv ====
`timescale 1ns/1ps

module op_issue #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  head_valid_i,
    input  logic                  issue_i,
    input  v850_dec_pkg::dec_op_t dec_i,
    input  logic                  op_credit_i,
    output logic                  pop_o,
    output logic                  op_valid_o,
    output v850_dec_pkg::dec_op_t op_o
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             has_credit;
    logic             fire;         // Head issues this cycle
    logic [CNT_W:0]   in_flight;    // Outputs execute still holds, seen at the ports

    assign has_credit = (credit_cnt != '0);
    // Non-issuing heads drain without a credit
    assign pop_o      = head_valid_i && (!issue_i || has_credit);
    assign fire       = pop_o && issue_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= fire;
            // Spent at issue so a stale count never double-books
            if (fire && !op_credit_i) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (!fire && op_credit_i) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            op_o <= dec_i;
        end
    end

    // Port-side count of outputs not yet credited back
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + op_valid_o - op_credit_i;
        end
    end

    // Execute returns no more credits than were spent
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        credit_cnt <= CNT_W'(OUT_CREDITS)
    ) else $error("op_issue: credit count above OUT_CREDITS");

    // A new output needs a slot freed before the cycle it issued in
    a_valid_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        op_valid_o |-> (in_flight + $past(op_credit_i)) < OUT_CREDITS
    ) else $error("op_issue: op_valid_o raised without a credit");

endmodule

// ==== rtl/v850_dec_pkg.sv ====
package v850_dec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_GR     = 32;

    // Major opcode, bits 10:5
    typedef enum logic [5:0] {
        OP_AND      = 6'b001010,
        OP_ADD      = 6'b001110,
        OP_ADD_IMM5 = 6'b010010,
        OP_ADDI     = 6'b110000,
        OP_ANDI     = 6'b110110,
        OP_EXT      = 6'b111111    // Formats IX..XII, sub-opcode in upper half
    } op_e;

    // Sub-opcode, bits 26:16
    typedef enum logic [10:0] {
        SUB_BSW = 11'b01101000000,
        SUB_BSH = 11'b01101000010,
        SUB_ADF = 11'b01110100000  // cccc field taken as zero
    } sub_op_e;

    localparam logic [3:0] BCOND_OP = 4'b1011;  // Format III, bits 10:7

    typedef enum logic [3:0] {
        COND_V   = 4'b0000, COND_C  = 4'b0001, COND_Z  = 4'b0010, COND_NH = 4'b0011,
        COND_N   = 4'b0100, COND_T  = 4'b0101, COND_LT = 4'b0110, COND_LE = 4'b0111,
        COND_NV  = 4'b1000, COND_NC = 4'b1001, COND_NZ = 4'b1010, COND_H  = 4'b1011,
        COND_P   = 4'b1100, COND_SAT = 4'b1101, COND_GE = 4'b1110, COND_GT = 4'b1111
    } cond_e;

    // Execute circuit select
    typedef enum logic [4:0] {
        UNIT_NONE = 5'd0,
        UNIT_ADD  = 5'd1,
        UNIT_AND  = 5'd2,
        UNIT_BSH  = 5'd6,
        UNIT_BSW  = 5'd7
    } unit_e;

    // z at bit 0 up to sat at bit 4
    typedef struct packed {
        logic sat;
        logic cy;
        logic ov;
        logic s;
        logic z;
    } psw_t;

    typedef struct packed {
        logic [15:0]           upper;   // Next halfword, unused for 16-bit forms
        logic [REG_ADDR_W-1:0] reg2;
        op_e                   opcode;
        logic [REG_ADDR_W-1:0] reg1;    // imm5 in format II
    } fmt_i_t;

    typedef struct packed {
        logic [15:0] upper;
        logic [4:0]  disp_hi;           // disp9 bits 8:4
        logic [3:0]  opcode;
        logic [2:0]  disp_lo;           // disp9 bits 3:1
        cond_e       cond;
    } fmt_iii_t;

    typedef struct packed {
        logic [15:0]           imm16;
        logic [REG_ADDR_W-1:0] reg2;
        op_e                   opcode;
        logic [REG_ADDR_W-1:0] reg1;
    } fmt_vi_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] reg3;
        logic [5:0]            sub_hi;
        cond_e                 cond;
        logic                  sub_lo;
        logic [REG_ADDR_W-1:0] reg2;
        op_e                   opcode;
        logic [REG_ADDR_W-1:0] reg1;
    } fmt_xi_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] reg3;
        sub_op_e               sub;
        logic [REG_ADDR_W-1:0] reg2;
        op_e                   opcode;
        logic [REG_ADDR_W-1:0] reg1;    // Must be zero
    } fmt_xii_t;

    typedef union packed {
        fmt_i_t   fmt_i;
        fmt_iii_t fmt_iii;
        fmt_vi_t  fmt_vi;
        fmt_xi_t  fmt_xi;
        fmt_xii_t fmt_xii;
    } inst_u;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0]       opa;
        logic [XLEN-1:0]       opb;
        logic                  incr;     // Carry-in for ADF
        logic [REG_ADDR_W-1:0] dest;
        unit_e                 unit;
    } dec_op_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// ==== rtl/v850_decode_top.sv ====
`timescale 1ns/1ps

module v850_decode_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  fetch_valid_i,
    input  v850_dec_pkg::fetch_t  fetch_i,
    input  v850_dec_pkg::psw_t    psw_i,
    input  v850_dec_pkg::wb_t     wb_i,
    input  logic                  op_credit_i,
    output logic                  fetch_credit_o,
    output logic                  op_valid_o,
    output v850_dec_pkg::dec_op_t op_o
);

    import v850_dec_pkg::*;

    logic                  head_valid;
    fetch_t                head;
    logic                  pop;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;
    logic [XLEN-1:0]       rdata_a;
    logic [XLEN-1:0]       rdata_b;
    cond_e                 cond;
    logic                  cond_ok;
    logic                  cond_valid;
    dec_op_t               dec;
    logic                  issue;

    inst_fifo #(
        .IN_DEPTH (IN_DEPTH)
    ) i_inst_fifo (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_i       (fetch_valid_i),
        .data_i       (fetch_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .credit_o     (fetch_credit_o)
    );

    gr_file i_gr_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (wb_i),
        .ra_i      (ra),
        .rb_i      (rb),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    // Flags taken live, in the pop cycle
    cond_eval i_cond_eval (
        .cond_i       (cond),
        .psw_i        (psw_i),
        .cond_ok_o    (cond_ok),
        .cond_valid_o (cond_valid)
    );

    field_decode i_field_decode (
        .head_i       (head),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .cond_ok_i    (cond_ok),
        .cond_valid_i (cond_valid),
        .ra_o         (ra),
        .rb_o         (rb),
        .cond_o       (cond),
        .dec_o        (dec),
        .issue_o      (issue)
    );

    op_issue #(
        .OUT_CREDITS (OUT_CREDITS)
    ) i_op_issue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .issue_i      (issue),
        .dec_i        (dec),
        .op_credit_i  (op_credit_i),
        .pop_o        (pop),
        .op_valid_o   (op_valid_o),
        .op_o         (op_o)
    );

endmodule

// ==== tests/dec_ref.svh ====
`ifndef DEC_REF_SVH
`define DEC_REF_SVH

// cccc[3] inverts the base test except for T and SAT
function automatic logic cond_ref(input logic [3:0] cc, input psw_t f);
    logic base;
    case (cc[2:0])
        3'd0: base = f.ov;
        3'd1: base = f.cy;
        3'd2: base = f.z;
        3'd3: base = f.cy | f.z;                // Not higher
        3'd4: base = f.s;
        3'd6: base = f.s ^ f.ov;                // Signed less than
        3'd7: base = (f.s ^ f.ov) | f.z;
        default: base = 1'b1;
    endcase
    if (cc[2:0] == 3'd5) begin
        return cc[3] ? f.sat : 1'b1;            // 0101 always true and 1101 tests SAT
    end
    return cc[3] ? !base : base;
endfunction

// Returns 1 with the expected bundle when the word issues
// Register values come from gr_model of the enclosing testbench
function automatic logic dec_ref(
    input  logic [31:0] pc,
    input  logic [31:0] word,
    input  psw_t        flags,
    output dec_op_t     exp
);
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [4:0]  r3;
    logic [31:0] a;
    logic [31:0] b;
    logic [8:0]  disp;
    logic        go;
    r1   = word[4:0];
    r2   = word[15:11];
    r3   = word[31:27];
    a    = gr_model[r1];
    b    = gr_model[r2];
    exp  = '0;
    go   = 1'b0;
    if (word[10:7] == 4'b1011) begin            // Bcond in format III
        disp = {word[15:11], word[6:4], 1'b0};
        go   = cond_ref(word[3:0], flags);
        if (go) begin
            exp.opa  = {{23{disp[8]}}, disp};
            exp.opb  = pc;
            exp.unit = UNIT_ADD;
        end
        return go;
    end
    go = 1'b1;
    exp.dest = r2;
    case (word[10:5])
        6'b001110: begin                        // ADD reg
            exp.opa  = a;
            exp.opb  = b;
            exp.unit = UNIT_ADD;
        end
        6'b010010: begin                        // ADD imm5
            exp.opa  = {{27{r1[4]}}, r1};
            exp.opb  = b;
            exp.unit = UNIT_ADD;
        end
        6'b110000: begin                        // ADDI
            exp.opa  = a;
            exp.opb  = {{16{word[31]}}, word[31:16]};
            exp.unit = UNIT_ADD;
        end
        6'b001010: begin                        // AND
            exp.opa  = a;
            exp.opb  = b;
            exp.unit = UNIT_AND;
        end
        6'b110110: begin                        // ANDI zero-extends
            exp.opa  = a;
            exp.opb  = {16'h0000, word[31:16]};
            exp.unit = UNIT_AND;
        end
        6'b111111: begin
            exp      = '0;
            exp.dest = r3;
            if (word[26:21] == 6'b011101 && !word[16] && word[20:17] != 4'b1101) begin
                exp.opa  = a;                    // ADF
                exp.opb  = b;
                exp.incr = cond_ref(word[20:17], flags);
                exp.unit = UNIT_ADD;
            end else if (r1 == 5'd0 && word[26:16] == 11'b01101000010) begin
                for (int i = 0; i < 4; i++) begin
                    exp.opb[8*i +: 8] = b[8*(i ^ 1) +: 8];
                end
                exp.unit = UNIT_BSH;
            end else if (r1 == 5'd0 && word[26:16] == 11'b01101000000) begin
                for (int i = 0; i < 4; i++) begin
                    exp.opb[8*i +: 8] = b[8*(3 - i) +: 8];
                end
                exp.unit = UNIT_BSW;
            end else begin
                go = 1'b0;
            end
        end
        default: go = 1'b0;                      // Dropped or unknown encoding
    endcase
    if (!go) exp = '0;
    return go;
endfunction

`endif

// ==== tests/tb_v850_decode.sv ====
`timescale 1ns/1ps

module tb_v850_decode;

    import v850_dec_pkg::*;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int HOLD_CYCLES = 30;
    localparam int DRAIN_LIMIT = 100;     // Longest drain of a full buffer under slow release
    localparam int N_INSTS     = 40 + 32 + 32 + 16 + 40 + 12;
    // Instructions, register preloads, execute hold and reset
    localparam int CYCLE_LIMIT = 4 * N_INSTS + 200 + 6 * (NUM_GR + 1) + HOLD_CYCLES + 10;

    logic    clk = 1'b0;
    logic    rst_n_i;
    logic    fetch_valid_i;
    fetch_t  fetch_i;
    psw_t    psw_i;
    wb_t     wb_i;
    logic    op_credit_i;
    logic    fetch_credit_o;
    logic    op_valid_o;
    dec_op_t op_o;

    logic [31:0] gr_model [NUM_GR];   // Expected register contents
    dec_op_t     exp_q [$];
    dec_op_t     exp_head;
    int          seed     = 32'h85c6_c4da;
    int          crd_seed = 32'h85c6_c4da;  // Execute model stream
    int          fetch_cred;
    int          exec_held;          // Slots held by execute
    int          hold_cnt;
    logic        slow_release;
    logic        starved;
    logic [31:0] pc_cur;
    int          cycles;
    int          err_cnt;
    int          n_tests;
    int          n_sent;
    int          n_out;
    int          t_sent;
    int          t_exp;
    int          t_out;
    int          t_back;
    int          t_err0;

    `include "dec_ref.svh"

    always #5 clk = ~clk;

    v850_decode_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_v850_decode_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_i        (fetch_i),
        .psw_i          (psw_i),
        .wb_i           (wb_i),
        .op_credit_i    (op_credit_i),
        .fetch_credit_o (fetch_credit_o),
        .op_valid_o     (op_valid_o),
        .op_o           (op_o)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles, outputs lost or stalled", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Credit counting, compare and execute model run where outputs are stable
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (fetch_credit_o) begin
                fetch_cred++;
                t_back++;
                if (fetch_cred > IN_DEPTH) begin
                    $display("Fetch credit returned at %0t with no entry outstanding", $time);
                    err_cnt++;
                end
            end
            if (op_valid_o) begin
                t_out++;
                n_out++;
                exec_held++;
                if (exec_held > OUT_CREDITS) begin
                    $display("Output at %0t went beyond the execute credits granted", $time);
                    err_cnt++;
                end
                if (exp_q.size() == 0) begin
                    $display("Output at %0t with no instruction expected to issue", $time);
                    err_cnt++;
                end else begin
                    exp_head = exp_q.pop_front();
                    if (op_o !== exp_head) begin
                        $display("[ERROR] %0t: op_o got opa=%h opb=%h incr=%b dest=%0d unit=%0d",
                                 $time, op_o.opa, op_o.opb, op_o.incr, op_o.dest, op_o.unit);
                        $display("[ERROR] %0t: expected opa=%h opb=%h incr=%b dest=%0d unit=%0d",
                                 $time, exp_head.opa, exp_head.opb, exp_head.incr,
                                 exp_head.dest, exp_head.unit);
                        err_cnt++;
                    end
                end
            end
            op_credit_i = 1'b0;
            if (hold_cnt > 0) begin
                hold_cnt--;                      // Back-pressure window
            end else if (exec_held > 0 && (!slow_release || ($random(crd_seed) & 1))) begin
                op_credit_i = 1'b1;
                exec_held--;
            end
        end
    end

    // Waits for a fetch credit, predicts the result and pushes one word
    task automatic send(input logic [31:0] word);
        dec_op_t exp;
        logic    go;
        while (fetch_cred == 0) begin
            starved = 1'b1;
            @(negedge clk);
        end
        pc_cur = pc_cur + 32'd4;
        go = dec_ref(pc_cur, word, psw_i, exp);
        if (go) begin
            exp_q.push_back(exp);
            t_exp++;
        end
        fetch_i.pc    = pc_cur;
        fetch_i.inst  = word;
        fetch_valid_i = 1'b1;
        fetch_cred--;
        t_sent++;
        n_sent++;
        @(negedge clk);
        fetch_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((fetch_cred != IN_DEPTH || exp_q.size() != 0) && waited < DRAIN_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    // Flags change only once every entry has been popped
    task automatic set_flags(input logic [4:0] f);
        while (fetch_cred != IN_DEPTH) @(negedge clk);
        psw_i = f;
    endtask

    task automatic preload_regs();
        logic [31:0] v;
        for (int r = 0; r < NUM_GR; r++) begin
            v = $random(seed);
            wb_i = '{we: 1'b1, addr: r[4:0], data: v};
            gr_model[r] = (r == 0) ? 32'h0 : v;  // r0 write ignored
            @(negedge clk);
        end
        wb_i.we = 1'b0;
        @(negedge clk);
    endtask

    task automatic start_test();
        t_sent = 0;
        t_exp  = 0;
        t_out  = 0;
        t_back = 0;
        t_err0 = err_cnt;
        preload_regs();
    endtask

    task automatic end_test(input string name);
        wait_drained();
        if (t_back != t_sent) begin
            $display("%s: %0d fetch credits back for %0d sent", name, t_back, t_sent);
            err_cnt++;
        end
        if (t_out != t_exp) begin
            $display("%s: %0d outputs seen, %0d expected", name, t_out, t_exp);
            err_cnt++;
        end
        n_tests++;
        $display("%-12s sent %0d, issued %0d, errors %0d  %s", name, t_sent, t_out,
                 err_cnt - t_err0, (err_cnt == t_err0) ? "ok" : "FAIL");
    endtask

    task automatic send_alu();
        logic [5:0]  ops [5];
        logic [31:0] r;
        ops = '{6'b001110, 6'b010010, 6'b110000, 6'b001010, 6'b110110};
        r = $random(seed);
        send({r[31:16], r[15:11], ops[$unsigned(r[10:8]) % 5], r[4:0]});
    endtask

    initial begin
        logic [31:0] r;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        psw_i         = '0;
        wb_i          = '0;
        op_credit_i   = 1'b0;
        fetch_cred    = IN_DEPTH;            // Fetch starts full
        exec_held     = 0;
        hold_cnt      = 0;
        slow_release  = 1'b0;
        starved       = 1'b0;
        pc_cur        = 32'h0000_1000;
        {cycles, err_cnt, n_tests, n_sent, n_out} = '0;
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;
        if (op_valid_o || fetch_credit_o) begin
            $display("Outputs not idle after reset");
            err_cnt++;
        end

        start_test();                        // ALU forms
        for (int i = 0; i < 40; i++) send_alu();
        end_test("alu");

        start_test();                        // ADF with every cccc twice
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            set_flags(r[4:0]);
            send({r[31:27], 6'b011101, 4'(i % 16), 1'b0, r[15:11], 6'h3f, r[9:5]});
        end
        end_test("adf");

        start_test();                        // Bcond taken and not taken
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            set_flags(r[4:0]);
            send({r[31:16], r[15:11], 4'b1011, r[10:8], 4'(i % 16)});
        end
        end_test("bcond");

        start_test();                        // BSH and BSW alternate
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            send({r[31:27], (i % 2) ? 11'b01101000000 : 11'b01101000010, r[15:11], 6'h3f, 5'd0});
        end
        end_test("byte_swap");

        start_test();                        // Execute withholds and then trickles credits
        starved      = 1'b0;
        hold_cnt     = HOLD_CYCLES;
        slow_release = 1'b1;
        for (int i = 0; i < 40; i++) send_alu();
        wait_drained();
        slow_release = 1'b0;
        if (!starved) begin
            $display("Fetch never ran out of credits under back-pressure");
            err_cnt++;
        end
        end_test("backpress");

        start_test();                        // r0 reads and unsupported words
        r = $random(seed);
        send({r[31:16], 5'd0, 6'b001110, 5'd0});           // ADD r0, r0
        send({r[31:16], 5'd7, 6'b001010, 5'd0});           // AND r0, r7
        send({r[31:16], 5'd0, 6'b010010, r[4:0]});         // ADD imm5, r0
        send({r[31:16], 5'd3, 6'b110000, 5'd0});           // ADDI from r0
        send({r[31:16], 5'd0, 6'b110110, 5'd0});
        send({5'd2, 11'b01101000000, 5'd0, 6'h3f, 5'd0});  // BSW of r0
        send({r[31:16], 5'd3, 6'b000000, 5'd4});           // MOV is dropped
        send({r[31:16], 5'd3, 6'b000001, 5'd4});           // NOT is dropped
        send({r[31:16], 5'd3, 6'b111001, 5'd4});
        send({5'd2, 11'h7ff, 5'd3, 6'h3f, 5'd4});          // Unknown sub-opcode
        send({5'd2, 11'b01101000010, 5'd3, 6'h3f, 5'd1});  // BSH with reg1 set
        send({5'd2, 6'b011101, 4'h2, 1'b1, 5'd3, 6'h3f, 5'd4});  // ADF bit 16 set
        end_test("r0_unsup");

        $display("Summary: %0d tests, %0d sent, %0d outputs, %0d errors",
                 n_tests, n_sent, n_out, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
